/* issue_pkg.sv */
/*
 * issue stage package
 * widths, opcode and class encodings, instruction field positions
 */
`default_nettype none

package issue_pkg;

   // lanes per issue group
   localparam int ISSUE_WIDTH = 2;

   // field positions inside a 32-bit instruction
   localparam int OPC_MSB = 31;
   localparam int RD_LSB  = 21;
   localparam int RJ_LSB  = 16;
   localparam int RK_LSB  = 11;

   typedef logic [31:0] word_t;
   typedef logic [31:0] pc_t;
   typedef logic [31:0] inst_t;
   typedef logic [4:0]  reg_addr_t;

   // opcode field, bits 31:26
   // unlisted codes decode as no-op
   typedef enum logic [5:0] {
      OP_ADD  = 6'h01,
      OP_SUB  = 6'h02,
      OP_ADDI = 6'h03,
      OP_LD   = 6'h04,
      OP_ST   = 6'h05,
      OP_BEQ  = 6'h06,
      OP_JMP  = 6'h07
   } opcode_e;

   // class handed to execute
   typedef enum logic [1:0] {
      CLS_ALU    = 2'd0,
      CLS_MEM    = 2'd1,
      CLS_BRANCH = 2'd2,
      CLS_NOP    = 2'd3
   } inst_class_e;

endpackage

`default_nettype wire

/* issue_lane_if.sv */
/*
 * one lane of decoded instruction, decoder to arbiter
 */
`default_nettype none

interface issue_lane_if
   import issue_pkg::*;
();
   logic        valid;
   pc_t         pc;
   inst_class_e cls;
   opcode_e     alu_op;
   reg_addr_t   rd;
   logic        we;
   // operands after immediate select
   word_t       src1;
   word_t       src2;
   // register read side
   logic        re1;
   logic        re2;
   reg_addr_t   raddr1;
   reg_addr_t   raddr2;
   // hazard and branch info
   logic        is_mem;
   logic        br_taken;
   pc_t         br_target;

   modport dec (output valid, pc, cls, alu_op, rd, we, src1, src2, re1, re2,
                raddr1, raddr2, is_mem, br_taken, br_target);
   modport arb (input valid, pc, cls, alu_op, rd, we, src1, src2, re1, re2,
                raddr1, raddr2, is_mem, br_taken, br_target);
endinterface

`default_nettype wire

/* fetch_pair_buffer.sv */
/*
 * fetch pair buffer
 * two slots between fetch and decode, shifts line 2 down on single issue
 */
`default_nettype none

module fetch_pair_buffer
   import issue_pkg::*;
(
   input  logic  clk,
   input  logic  rst_i,
   // from fetch
   input  logic  line1_valid_i,
   input  logic  line2_valid_i,
   input  pc_t   pc_i,
   input  inst_t inst1_i,
   input  inst_t inst2_i,
   // from arbiter
   input  logic  stage_allowin_i,
   input  logic  issue_one_i,
   input  logic  issue_two_i,
   input  logic  branch_flush_i,
   input  logic  excep_flush_i,
   // to decoders
   output logic  slot1_valid_o,
   output logic  slot2_valid_o,
   output pc_t   slot1_pc_o,
   output pc_t   slot2_pc_o,
   output inst_t slot1_inst_o,
   output inst_t slot2_inst_o
);

   logic  slot1_valid;
   logic  slot2_valid;
   pc_t   slot1_pc;
   pc_t   slot2_pc;
   inst_t slot1_inst;
   inst_t slot2_inst;
   logic  load;
   pc_t   line2_pc;

   // any lane offered while stage open
   assign load     = stage_allowin_i && (line1_valid_i || line2_valid_i);
   assign line2_pc = pc_i + 32'd4;

   // slot valids
   // slot 2 only ever holds something behind a valid slot 1
   always_ff @(posedge clk) begin
      if (rst_i || branch_flush_i || excep_flush_i) begin
         slot1_valid <= 1'b0;
         slot2_valid <= 1'b0;
      end else if (load) begin
         slot1_valid <= 1'b1;
         slot2_valid <= line1_valid_i && line2_valid_i;
      end else if (issue_two_i) begin
         slot1_valid <= 1'b0;
         slot2_valid <= 1'b0;
      end else if (issue_one_i) begin
         slot1_valid <= slot2_valid;
         slot2_valid <= 1'b0;
      end
   end

   // payload
   always_ff @(posedge clk) begin
      if (load) begin
         // lone line 2 goes straight to slot 1
         slot1_pc   <= line1_valid_i ? pc_i : line2_pc;
         slot1_inst <= line1_valid_i ? inst1_i : inst2_i;
         slot2_pc   <= line2_pc;
         slot2_inst <= inst2_i;
      end else if (issue_one_i) begin
         slot1_pc   <= slot2_pc;
         slot1_inst <= slot2_inst;
      end
   end

   assign slot1_valid_o = slot1_valid;
   assign slot2_valid_o = slot2_valid;
   assign slot1_pc_o    = slot1_pc;
   assign slot2_pc_o    = slot2_pc;
   assign slot1_inst_o  = slot1_inst;
   assign slot2_inst_o  = slot2_inst;

   // arbiter picks at most one issue mode per cycle
   a_issue_onehot: assert property (
      @(posedge clk) disable iff (rst_i)
      !(issue_one_i && issue_two_i)
   ) else $error("issue_one and issue_two both high");

endmodule

`default_nettype wire

/* lane_decoder.sv */
/*
 * lane decoder
 * splits fields, forms read addresses, picks operands, resolves branches
 */
`default_nettype none

module lane_decoder
   import issue_pkg::*;
(
   input  logic      lane_valid_i,
   input  pc_t       lane_pc_i,
   input  inst_t     lane_inst_i,
   input  word_t     rdata1_i,
   input  word_t     rdata2_i,
   issue_lane_if.dec lane
);

   opcode_e     op;
   reg_addr_t   rd;
   reg_addr_t   rj;
   reg_addr_t   rk;
   word_t       imm;
   inst_class_e cls;
   logic        writes;
   logic        re1;
   logic        re2;
   logic        use_imm;
   logic        src2_is_rd;
   logic        is_sub;
   logic        is_beq;
   logic        is_jmp;

   // field split
   assign op  = opcode_e'(lane_inst_i[OPC_MSB -: 6]);
   assign rd  = lane_inst_i[RD_LSB +: $bits(reg_addr_t)];
   assign rj  = lane_inst_i[RJ_LSB +: $bits(reg_addr_t)];
   assign rk  = lane_inst_i[RK_LSB +: $bits(reg_addr_t)];
   // imm16, sign extended
   assign imm = {{16{lane_inst_i[15]}}, lane_inst_i[15:0]};

   always_comb begin
      cls        = CLS_NOP;
      writes     = 1'b0;
      re1        = 1'b0;
      re2        = 1'b0;
      use_imm    = 1'b0;
      src2_is_rd = 1'b0;
      is_sub     = 1'b0;
      is_beq     = 1'b0;
      is_jmp     = 1'b0;
      case (op)
         OP_ADD, OP_SUB: begin
            cls    = CLS_ALU;
            writes = 1'b1;
            re1    = 1'b1;
            re2    = 1'b1;
            is_sub = (op == OP_SUB);
         end
         OP_ADDI, OP_LD: begin
            cls     = (op == OP_LD) ? CLS_MEM : CLS_ALU;
            writes  = 1'b1;
            re1     = 1'b1;
            use_imm = 1'b1;
         end
         OP_ST: begin
            // store data rides in src2
            cls        = CLS_MEM;
            re1        = 1'b1;
            re2        = 1'b1;
            src2_is_rd = 1'b1;
         end
         OP_BEQ: begin
            // compares rj against rd
            cls        = CLS_BRANCH;
            re1        = 1'b1;
            re2        = 1'b1;
            src2_is_rd = 1'b1;
            is_beq     = 1'b1;
         end
         OP_JMP: begin
            cls    = CLS_BRANCH;
            is_jmp = 1'b1;
         end
         default: cls = CLS_NOP;
      endcase
   end

   assign lane.valid  = lane_valid_i;
   assign lane.pc     = lane_pc_i;
   assign lane.cls    = cls;
   assign lane.alu_op = is_sub ? OP_SUB : OP_ADD;
   assign lane.rd     = rd;
   // r0 is never written
   assign lane.we     = writes && (rd != '0);

   // unused read ports park on r0
   assign lane.re1    = re1;
   assign lane.re2    = re2;
   assign lane.raddr1 = re1 ? rj : '0;
   assign lane.raddr2 = re2 ? (src2_is_rd ? rd : rk) : '0;

   assign lane.src1   = rdata1_i;
   assign lane.src2   = use_imm ? imm : rdata2_i;
   assign lane.is_mem = (cls == CLS_MEM);

   // branch resolves here, jmp always taken
   assign lane.br_taken  = lane_valid_i && (is_jmp || (is_beq && (rdata1_i == rdata2_i)));
   assign lane.br_target = lane_pc_i + {imm[29:0], 2'b00};

endmodule

`default_nettype wire

/* issue_arbiter.sv */
/*
 * issue arbiter
 * dual or single issue choice, redirect, flush and allowin generation
 */
`default_nettype none

module issue_arbiter
   import issue_pkg::*;
(
   input  logic      clk,
   input  logic      rst_i,
   input  logic      next_allowin_i,
   input  logic      excep_flush_i,
   issue_lane_if.arb lane1,
   issue_lane_if.arb lane2,
   output logic      issue_one_o,
   output logic      issue_two_o,
   output logic      branch_flush_o,
   output logic      stage_allowin_o,
   output logic      jmp_flag_o,
   output pc_t       jmp_addr_o,
   output logic      line1_issue_valid_o,
   output logic      line2_issue_valid_o
);

   logic raw_dep;
   logic dual_ok;
   logic go;

   // line 2 reads what line 1 writes
   assign raw_dep = lane1.we && (lane1.rd != '0) &&
                    ((lane2.re1 && (lane2.raddr1 == lane1.rd)) ||
                     (lane2.re2 && (lane2.raddr2 == lane1.rd)));

   // taken line 1 cancels line 2, mem in line 2 goes alone
   assign dual_ok = lane1.valid && lane2.valid && !lane1.br_taken &&
                    !lane2.is_mem && !raw_dep;

   // slot 1 always leaves first
   assign go = next_allowin_i && lane1.valid && !excep_flush_i;

   assign line1_issue_valid_o = go;
   assign line2_issue_valid_o = go && dual_ok;

   // lone line 1 empties the buffer too
   assign issue_two_o = go && (dual_ok || !lane2.valid);
   assign issue_one_o = go && lane2.valid && !dual_ok;

   // line 2 branch counts only when paired
   assign jmp_flag_o     = go && (lane1.br_taken || (dual_ok && lane2.br_taken));
   assign jmp_addr_o     = lane1.br_taken ? lane1.br_target : lane2.br_target;
   assign branch_flush_o = jmp_flag_o;

   // open when empty or draining this cycle
   assign stage_allowin_o = !excep_flush_i && !branch_flush_o &&
                            (!lane1.valid || issue_two_o);

   a_line2_needs_line1: assert property (
      @(posedge clk) disable iff (rst_i)
      line2_issue_valid_o |-> line1_issue_valid_o
   ) else $error("line 2 issued without line 1");

   a_no_valid_blocked: assert property (
      @(posedge clk) disable iff (rst_i)
      !next_allowin_i |-> !(line1_issue_valid_o || line2_issue_valid_o)
   ) else $error("valid raised under back-pressure");

   // buffer is cleared by the redirect, nothing left to issue
   a_redirect_drains: assert property (
      @(posedge clk) disable iff (rst_i)
      jmp_flag_o |=> !line1_issue_valid_o
   ) else $error("issue right after redirect");

endmodule

`default_nettype wire

/* dual_issue_stage.sv */
/*
 * dual issue stage top
 * pair buffer, two lane decoders and the issue arbiter
 */
`default_nettype none

module dual_issue_stage
   import issue_pkg::*;
(
   input  logic                             clk,
   input  logic                             rst_i,
   // fetch side
   input  logic                             line1_valid_i,
   input  logic                             line2_valid_i,
   input  pc_t                              pc_i,
   input  inst_t                            inst1_i,
   input  inst_t                            inst2_i,
   output logic                             now_allowin_o,
   // execute side
   input  logic                             next_allowin_i,
   input  logic                             excep_flush_i,
   // register file, lane 1 in [1:0], lane 2 in [3:2]
   input  word_t     [2*ISSUE_WIDTH-1:0]    regs_rdata_i,
   output reg_addr_t [2*ISSUE_WIDTH-1:0]    regs_raddr_o,
   // redirect to fetch
   output logic                             jmp_flag_o,
   output pc_t                              jmp_addr_o,
   // lane 1 to execute
   output logic                             line1_valid_o,
   output pc_t                              line1_pc_o,
   output inst_class_e                      line1_class_o,
   output reg_addr_t                        line1_rd_o,
   output logic                             line1_we_o,
   output word_t                            line1_src1_o,
   output word_t                            line1_src2_o,
   // lane 2 to execute
   output logic                             line2_valid_o,
   output pc_t                              line2_pc_o,
   output inst_class_e                      line2_class_o,
   output reg_addr_t                        line2_rd_o,
   output logic                             line2_we_o,
   output word_t                            line2_src1_o,
   output word_t                            line2_src2_o
);

   logic  slot1_valid;
   logic  slot2_valid;
   pc_t   slot1_pc;
   pc_t   slot2_pc;
   inst_t slot1_inst;
   inst_t slot2_inst;
   logic  issue_one;
   logic  issue_two;
   logic  branch_flush;
   logic  stage_allowin;

   issue_lane_if lane1_if ();
   issue_lane_if lane2_if ();

   fetch_pair_buffer i_fetch_pair_buffer (
      .clk             (clk),
      .rst_i           (rst_i),
      .line1_valid_i   (line1_valid_i),
      .line2_valid_i   (line2_valid_i),
      .pc_i            (pc_i),
      .inst1_i         (inst1_i),
      .inst2_i         (inst2_i),
      .stage_allowin_i (stage_allowin),
      .issue_one_i     (issue_one),
      .issue_two_i     (issue_two),
      .branch_flush_i  (branch_flush),
      .excep_flush_i   (excep_flush_i),
      .slot1_valid_o   (slot1_valid),
      .slot2_valid_o   (slot2_valid),
      .slot1_pc_o      (slot1_pc),
      .slot2_pc_o      (slot2_pc),
      .slot1_inst_o    (slot1_inst),
      .slot2_inst_o    (slot2_inst)
   );

   lane_decoder i_lane_decoder_1 (
      .lane_valid_i (slot1_valid),
      .lane_pc_i    (slot1_pc),
      .lane_inst_i  (slot1_inst),
      .rdata1_i     (regs_rdata_i[0]),
      .rdata2_i     (regs_rdata_i[1]),
      .lane         (lane1_if.dec)
   );

   lane_decoder i_lane_decoder_2 (
      .lane_valid_i (slot2_valid),
      .lane_pc_i    (slot2_pc),
      .lane_inst_i  (slot2_inst),
      .rdata1_i     (regs_rdata_i[2]),
      .rdata2_i     (regs_rdata_i[3]),
      .lane         (lane2_if.dec)
   );

   issue_arbiter i_issue_arbiter (
      .clk                 (clk),
      .rst_i               (rst_i),
      .next_allowin_i      (next_allowin_i),
      .excep_flush_i       (excep_flush_i),
      .lane1               (lane1_if.arb),
      .lane2               (lane2_if.arb),
      .issue_one_o         (issue_one),
      .issue_two_o         (issue_two),
      .branch_flush_o      (branch_flush),
      .stage_allowin_o     (stage_allowin),
      .jmp_flag_o          (jmp_flag_o),
      .jmp_addr_o          (jmp_addr_o),
      .line1_issue_valid_o (line1_valid_o),
      .line2_issue_valid_o (line2_valid_o)
   );

   assign now_allowin_o = stage_allowin;

   // read addresses out to the register file
   assign regs_raddr_o[0] = lane1_if.raddr1;
   assign regs_raddr_o[1] = lane1_if.raddr2;
   assign regs_raddr_o[2] = lane2_if.raddr1;
   assign regs_raddr_o[3] = lane2_if.raddr2;

   // payload straight from the decoders
   assign line1_pc_o    = lane1_if.pc;
   assign line1_class_o = lane1_if.cls;
   assign line1_rd_o    = lane1_if.rd;
   assign line1_we_o    = lane1_if.we;
   assign line1_src1_o  = lane1_if.src1;
   assign line1_src2_o  = lane1_if.src2;
   assign line2_pc_o    = lane2_if.pc;
   assign line2_class_o = lane2_if.cls;
   assign line2_rd_o    = lane2_if.rd;
   assign line2_we_o    = lane2_if.we;
   assign line2_src1_o  = lane2_if.src1;
   assign line2_src2_o  = lane2_if.src2;

endmodule

`default_nettype wire

/* tb_dual_issue_stage.sv */
/*
 * testbench for the dual issue stage
 * trace driven fetch, register file model, in-order issue checker
 */
`default_nettype none

module tb_dual_issue_stage
   import issue_pkg::*;
();

   logic             clk;
   logic             rst_i;
   logic             line1_valid_i;
   logic             line2_valid_i;
   logic [31:0]      pc_i;
   logic [31:0]      inst1_i;
   logic [31:0]      inst2_i;
   logic             next_allowin_i;
   logic             excep_flush_i;
   logic [3:0][31:0] regs_rdata;
   logic [3:0][4:0]  regs_raddr;
   logic             now_allowin_o;
   logic             jmp_flag_o;
   logic [31:0]      jmp_addr_o;
   logic             l1_valid, l2_valid, l1_we, l2_we;
   logic [31:0]      l1_pc, l2_pc, l1_src1, l1_src2, l2_src1, l2_src2;
   logic [1:0]       l1_cls, l2_cls;
   logic [4:0]       l1_rd, l2_rd;

   // trace contents
   logic [31:0] mem [0:1023];
   logic [31:0] pair_test [0:63];
   logic [31:0] pair_pc [0:63];
   logic [31:0] pair_i1 [0:63];
   logic [31:0] pair_i2 [0:63];
   logic [31:0] pair_val [0:63];
   logic [31:0] pair_fl [0:63];
   logic [31:0] exp_kind [$];
   logic [31:0] exp_test [$];
   logic [31:0] exp_pc [$];
   logic [31:0] exp_rd [$];
   logic [31:0] exp_s1 [$];
   logic [31:0] exp_s2 [$];
   int          npairs;
   int          left_per_test [0:15];
   int          err_per_test [0:15];
   int          checks;
   int          errors;
   logic        trace_loaded;

   // shared between negedge monitor and drive process
   logic        accepted;
   logic        redirect_seen;
   logic [31:0] redirect_target;
   logic [31:0] lfsr;

   dual_issue_stage i_dual_issue_stage (
      .clk (clk), .rst_i (rst_i),
      .line1_valid_i (line1_valid_i), .line2_valid_i (line2_valid_i),
      .pc_i (pc_i), .inst1_i (inst1_i), .inst2_i (inst2_i),
      .now_allowin_o (now_allowin_o),
      .next_allowin_i (next_allowin_i), .excep_flush_i (excep_flush_i),
      .regs_rdata_i (regs_rdata), .regs_raddr_o (regs_raddr),
      .jmp_flag_o (jmp_flag_o), .jmp_addr_o (jmp_addr_o),
      .line1_valid_o (l1_valid), .line1_pc_o (l1_pc), .line1_class_o (l1_cls),
      .line1_rd_o (l1_rd), .line1_we_o (l1_we),
      .line1_src1_o (l1_src1), .line1_src2_o (l1_src2),
      .line2_valid_o (l2_valid), .line2_pc_o (l2_pc), .line2_class_o (l2_cls),
      .line2_rd_o (l2_rd), .line2_we_o (l2_we),
      .line2_src1_o (l2_src1), .line2_src2_o (l2_src2)
   );

   // register n holds n * 01010101, r0 reads zero
   always_comb begin
      for (int i = 0; i < 4; i++) begin
         regs_rdata[i] = {27'd0, regs_raddr[i]} * 32'h01010101;
      end
   end

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // galois lfsr, one step per bit
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
   endfunction

   // instruction the trace places at a pc
   function automatic logic [31:0] inst_at(input logic [31:0] pc);
      for (int k = 0; k < npairs; k++) begin
         if (pair_pc[k] == pc) return pair_i1[k];
         if (pair_pc[k] + 32'd4 == pc) return pair_i2[k];
      end
      return '0;
   endfunction

   // class sent to execute for each opcode
   function automatic logic [1:0] class_of(input logic [31:0] inst);
      case (inst[31:26])
         OP_ADD, OP_SUB, OP_ADDI: return CLS_ALU;
         OP_LD, OP_ST: return CLS_MEM;
         OP_BEQ, OP_JMP: return CLS_BRANCH;
         default: return CLS_NOP;
      endcase
   endfunction

   // alu ops and loads write rd, r0 never
   function automatic logic writes_rd(input logic [31:0] inst);
      logic [5:0] opc;
      opc = inst[31:26];
      return (opc == OP_ADD || opc == OP_SUB || opc == OP_ADDI || opc == OP_LD) &&
             (inst[25:21] != 5'd0);
   endfunction

   // count an entry against its test, report when the test is through
   task automatic retire_entry(input int t);
      checks++;
      left_per_test[t]--;
      if (left_per_test[t] == 0) begin
         $display("test %0d finished, %0d errors", t, err_per_test[t]);
      end
   endtask

   task automatic check_issue(input logic [31:0] pc, input logic [4:0] rd,
                              input logic [31:0] s1, input logic [31:0] s2,
                              input logic [1:0] cls, input logic we);
      int t;
      logic [31:0] inst;
      if (exp_kind.size() == 0) begin
         $display("an instruction at pc %h issued after the expected stream ended", pc);
         errors++;
         return;
      end
      t    = exp_test.pop_front();
      inst = inst_at(exp_pc[0]);
      assert (exp_kind[0] == 1 && exp_pc[0] == pc && exp_rd[0] == {27'd0, rd} &&
              exp_s1[0] == s1 && exp_s2[0] == s2 &&
              class_of(inst) == cls && writes_rd(inst) == we)
      else begin
         $display("ERR %0t: test %0d issue pc %h rd %0d src %h %h class %0d we %0b",
                  $time, t, pc, rd, s1, s2, cls, we);
         $display("ERR %0t: expected kind %0d pc %h rd %0d src %h %h class %0d we %0b",
                  $time, exp_kind[0], exp_pc[0], exp_rd[0], exp_s1[0], exp_s2[0],
                  class_of(inst), writes_rd(inst));
         errors++;
         err_per_test[t]++;
      end
      void'(exp_kind.pop_front());
      void'(exp_pc.pop_front());
      void'(exp_rd.pop_front());
      void'(exp_s1.pop_front());
      void'(exp_s2.pop_front());
      retire_entry(t);
   endtask

   task automatic check_redirect(input logic [31:0] target);
      int t;
      if (exp_kind.size() == 0) begin
         $display("a redirect to %h came after the expected stream ended", target);
         errors++;
         return;
      end
      t = exp_test.pop_front();
      assert (exp_kind[0] == 2 && exp_pc[0] == target)
      else begin
         $display("ERR %0t: test %0d redirect to %h, expected kind %0d value %h",
                  $time, t, target, exp_kind[0], exp_pc[0]);
         errors++;
         err_per_test[t]++;
      end
      void'(exp_kind.pop_front());
      void'(exp_pc.pop_front());
      void'(exp_rd.pop_front());
      void'(exp_s1.pop_front());
      void'(exp_s2.pop_front());
      retire_entry(t);
   endtask

   // outputs are settled by the falling edge
   always @(negedge clk) begin
      if (!rst_i) begin
         assert (next_allowin_i || !(l1_valid || l2_valid))
         else begin
            $display("ERR %0t: valid raised while next_allowin_i is low", $time);
            errors++;
         end
         assert (!(l2_valid && !l1_valid))
         else begin
            $display("ERR %0t: line 2 valid without line 1", $time);
            errors++;
         end
         if (l1_valid) check_issue(l1_pc, l1_rd, l1_src1, l1_src2, l1_cls, l1_we);
         if (l2_valid) check_issue(l2_pc, l2_rd, l2_src1, l2_src2, l2_cls, l2_we);
         if (jmp_flag_o) begin
            check_redirect(jmp_addr_o);
            redirect_seen   = 1'b1;
            redirect_target = jmp_addr_o;
         end
         accepted = (line1_valid_i || line2_valid_i) && now_allowin_o;
      end
   end

   // run limit scales with the trace
   initial begin
      wait (trace_loaded);
      repeat (npairs * 40) @(posedge clk);
      $display("watchdog expired before the trace was consumed");
      $display("TESTBENCH FAILED");
      $finish;
   end

   initial begin
      int ptr;
      int n;
      int idx;
      int idle;
      logic flush_now;
      rst_i          = 1'b1;
      line1_valid_i  = 1'b0;
      line2_valid_i  = 1'b0;
      pc_i           = '0;
      inst1_i        = '0;
      inst2_i        = '0;
      next_allowin_i = 1'b0;
      excep_flush_i  = 1'b0;
      accepted       = 1'b0;
      redirect_seen  = 1'b0;
      redirect_target = '0;
      lfsr           = 32'h12cb7161;
      checks         = 0;
      errors         = 0;
      trace_loaded   = 1'b0;
      for (int i = 0; i < 16; i++) begin
         left_per_test[i] = 0;
         err_per_test[i]  = 0;
      end

      // split the trace into pairs and the expected stream
      $readmemh("dual_issue_trace.txt", mem);
      ptr    = 0;
      npairs = 0;
      while (!$isunknown(mem[ptr]) && mem[ptr] != 0) begin
         pair_test[npairs] = mem[ptr];
         pair_pc[npairs]   = mem[ptr+1];
         pair_i1[npairs]   = mem[ptr+2];
         pair_i2[npairs]   = mem[ptr+3];
         pair_val[npairs]  = mem[ptr+4];
         pair_fl[npairs]   = mem[ptr+5];
         n                 = int'(mem[ptr+6]);
         ptr               = ptr + 7;
         for (int k = 0; k < n; k++) begin
            exp_test.push_back(pair_test[npairs]);
            exp_kind.push_back(mem[ptr]);
            exp_pc.push_back(mem[ptr+1]);
            left_per_test[pair_test[npairs]]++;
            if (mem[ptr] == 1) begin
               exp_rd.push_back(mem[ptr+2]);
               exp_s1.push_back(mem[ptr+3]);
               exp_s2.push_back(mem[ptr+4]);
               ptr = ptr + 5;
            end else begin
               exp_rd.push_back('0);
               exp_s1.push_back('0);
               exp_s2.push_back('0);
               ptr = ptr + 2;
            end
         end
         npairs++;
      end
      trace_loaded = 1'b1;

      repeat (16) @(posedge clk);
      #1 rst_i = 1'b0;

      // idle outputs right out of reset
      @(negedge clk);
      assert (now_allowin_o && !l1_valid && !l2_valid && !jmp_flag_o)
      else begin
         $display("ERR %0t: outputs not idle after reset", $time);
         errors++;
      end

      idx  = 0;
      idle = 0;
      while (idle < 20) begin
         @(posedge clk);
         #1;
         flush_now = 1'b0;
         if (accepted) begin
            flush_now = (pair_fl[idx] != 0);
            idx++;
         end
         accepted = 1'b0;
         // fetch skips to the redirect target
         if (redirect_seen) begin
            while (idx < npairs && pair_pc[idx] != redirect_target) idx++;
            redirect_seen = 1'b0;
         end
         lfsr           = lfsr_next(lfsr);
         // execute stays ready through a flush
         next_allowin_i = lfsr[0] || flush_now;
         excep_flush_i  = flush_now;
         if (!flush_now && idx < npairs) begin
            line1_valid_i = pair_val[idx][1];
            line2_valid_i = pair_val[idx][0];
            pc_i          = pair_pc[idx];
            inst1_i       = pair_i1[idx];
            inst2_i       = pair_i2[idx];
         end else begin
            line1_valid_i = 1'b0;
            line2_valid_i = 1'b0;
         end
         if (idx >= npairs && exp_kind.size() == 0) idle++;
      end

      for (int t = 1; t < 16; t++) begin
         if (left_per_test[t] != 0) begin
            $display("test %0d is missing %0d expected entries", t, left_per_test[t]);
            errors++;
         end
      end
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* all.f */
issue_pkg.sv
issue_lane_if.sv
fetch_pair_buffer.sv
lane_decoder.sv
issue_arbiter.sv
dual_issue_stage.sv
tb_dual_issue_stage.sv

/* Makefile */
# Verilator build, run, lint and clean for the dual issue stage

VERILATOR ?= verilator
TOP       ?= tb_dual_issue_stage
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= TESTBENCH PASSED
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass" && exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dual_issue_trace.txt */
// test pc inst1 inst2 valids(bit1 line1, bit0 line2) flush nexp, then nexp entries
// entry: 1 pc rd src1 src2 for an issue, 2 target for a redirect
1 00001000 04611000 0C85FFF0 3 0 2 1 00001000 3 01010101 02020202 1 00001004 4 05050505 FFFFFFF0
1 00001008 08C70800 05021800 3 0 2 1 00001008 6 07070707 01010101 1 0000100C 8 02020202 03030303
// raw dependency, load and store in line 2
2 00001010 05211000 0D490004 3 0 2 1 00001010 9 01010101 02020202 1 00001014 A 09090909 00000004
2 00001018 04221800 10850008 3 0 2 1 00001018 1 02020202 03030303 1 0000101C 4 05050505 00000008
2 00001020 0C400001 14660010 3 0 2 1 00001020 2 00000000 00000001 1 00001024 3 06060606 03030303
// taken beq in line 1, two wrong path pairs, then a not taken beq
3 00001028 18840006 04A10800 3 0 2 1 00001028 4 04040404 04040404 2 00001040
3 00001030 04E11000 04E11000 3 0 0
3 00001038 04E11000 04E11000 3 0 0
3 00001040 18410010 04642800 3 0 2 1 00001040 2 01010101 02020202 1 00001044 3 04040404 05050505
// jmp in line 2 of a dual pair, then beq in line 2 behind a dependency
4 00001048 0C220003 1C000003 3 0 3 1 00001048 1 02020202 00000003 1 0000104C 0 00000000 00000000 2 00001058
4 00001050 04E11000 04E11000 3 0 0
4 00001058 04A11000 18A50001 3 0 3 1 00001058 5 01010101 02020202 1 0000105C 5 05050505 05050505 2 00001060
// mixed pairs and lone lanes
5 00001060 04432000 08C20800 3 0 2 1 00001060 2 03030303 04040404 1 00001064 6 02020202 01010101
5 00001068 00000000 0CE17FFF 1 0 1 1 0000106C 7 01010101 00007FFF
5 00001070 1109FFFC 00000000 2 0 1 1 00001070 8 09090909 FFFFFFFC
// exception flush drops the marked pair
6 00001078 04611000 0C85FFF0 3 1 0
6 00001080 04611000 0C85FFF0 3 0 2 1 00001080 3 01010101 02020202 1 00001084 4 05050505 FFFFFFF0
0
